// File: project.f
verilog/axi_lite_pkg.sv
verilog/sram_pkg.sv
verilog/sram_controller.sv
verilog/axi_sram_controller.sv
test/sram_model.sv
test/axi_sram_controller_tb.sv

// File: Bender.yml
package:
  name: axi_sram_controller

dependencies: {}

sources:
  # packages first, then the sequencer and the AXI4-Lite top level
  - verilog/axi_lite_pkg.sv
  - verilog/sram_pkg.sv
  - verilog/sram_controller.sv
  - verilog/axi_sram_controller.sv

  # chip model and testbench
  - target: test
    files:
      - test/sram_model.sv
      - test/axi_sram_controller_tb.sv

// File: test/axi_sram_controller_tb.sv
`timescale 1ns/1ns
`default_nettype none

module axi_sram_controller_tb
  import axi_lite_pkg::*, sram_pkg::*;
();

  localparam int ADDR_WIDTH   = AXI_ADDR_WIDTH_DEFAULT;
  localparam int DATA_WIDTH   = AXI_DATA_WIDTH_DEFAULT;
  localparam int STRB_WIDTH   = (DATA_WIDTH + 7) / 8;
  localparam int WAIT_CYCLES  = 2;
  localparam int RESET_CYCLES = 16;
  localparam int DIRECTED_OPS = 18;
  localparam int RANDOM_OPS   = 200;
  localparam int MAX_DELAY    = 6;
  localparam int CYCLE_LIMIT  = RESET_CYCLES +
    (DIRECTED_OPS + RANDOM_OPS) * (WAIT_CYCLES + 3 + MAX_DELAY + 4);

  logic                  axi_clk;
  logic                  axi_resetn;
  logic [ADDR_WIDTH-1:0] axi_awaddr;
  logic                  axi_awvalid;
  logic                  axi_awready;
  logic [DATA_WIDTH-1:0] axi_wdata;
  logic [STRB_WIDTH-1:0] axi_wstrb;
  logic                  axi_wvalid;
  logic                  axi_wready;
  axi_resp_t             axi_bresp;
  logic                  axi_bvalid;
  logic                  axi_bready;
  logic [ADDR_WIDTH-1:0] axi_araddr;
  logic                  axi_arvalid;
  logic                  axi_arready;
  logic [DATA_WIDTH-1:0] axi_rdata;
  axi_resp_t             axi_rresp;
  logic                  axi_rvalid;
  logic                  axi_rready;
  logic [ADDR_WIDTH-1:0] sram_addr;
  wire  [DATA_WIDTH-1:0] sram_data;
  logic                  sram_we_n;
  logic                  sram_oe_n;
  logic                  sram_ce_n;

  string       test_name;
  integer      seed;
  int          cycle_count = 0;
  int          last_b_cycle = 0;
  int          last_r_cycle = 0;
  sram_state_t seq_state;

  // what memory should hold, and responses still owed by the DUT
  logic [DATA_WIDTH-1:0] shadow [logic [ADDR_WIDTH-1:0]];
  axi_resp_t             exp_bresp [$];
  logic [DATA_WIDTH-1:0] exp_rdata [$];

  axi_sram_controller #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) dut (.*);

  sram_model #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
  ) sram (
    .addr (sram_addr),
    .data (sram_data),
    .ce_n (sram_ce_n),
    .oe_n (sram_oe_n),
    .we_n (sram_we_n)
  );

  initial begin
    axi_clk = 1'b0;
    forever #10 axi_clk = ~axi_clk;
  end

  task automatic stop_run();
    $display("TEST FAILED");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_resp(input string what, input axi_resp_t expected, input axi_resp_t actual);
    if (actual !== expected) begin
      $display("error [%s] %s: expected %s (%b), actual %s (%b)", test_name, what,
               expected.name(), expected, actual.name(), actual);
      stop_run();
    end
  endtask

  task automatic check_data(input string what, input logic [DATA_WIDTH-1:0] expected,
                            input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("error [%s] %s: expected %h, actual %h", test_name, what, expected, actual);
      stop_run();
    end
  endtask

  task automatic compare_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error [%s] %s: expected %b, actual %b", test_name, what, expected, actual);
      stop_run();
    end
  endtask

  task automatic verify_idle_pins();
    compare_flag("awready", 1'b0, axi_awready);
    compare_flag("wready", 1'b0, axi_wready);
    compare_flag("arready", 1'b0, axi_arready);
    compare_flag("bvalid", 1'b0, axi_bvalid);
    compare_flag("rvalid", 1'b0, axi_rvalid);
    compare_flag("sram_ce_n", 1'b1, sram_ce_n);
    compare_flag("sram_we_n", 1'b1, sram_we_n);
    compare_flag("sram_oe_n", 1'b1, sram_oe_n);
  endtask

  // inputs change 2 ns after the rising edge
  task automatic step_to_drive();
    @(posedge axi_clk);
    #2;
  endtask

  function automatic logic [DATA_WIDTH-1:0] initial_word(input logic [ADDR_WIDTH-1:0] a);
    logic [31:0] wide;
    wide = 32'(a);
    return DATA_WIDTH'((wide * 32'h0000_9e37) ^ (wide >> 5) ^ 32'h0000_5a5a);
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_read(input logic [ADDR_WIDTH-1:0] a);
    if (shadow.exists(a)) begin
      return shadow[a];
    end
    return initial_word(a);
  endfunction

  task automatic axi_write(input logic [ADDR_WIDTH-1:0] addr, input logic [DATA_WIDTH-1:0] data,
                           input logic [STRB_WIDTH-1:0] strb = '1, input int bready_delay = 0);
    axi_resp_t held;
    axi_awaddr  = addr;
    axi_wdata   = data;
    axi_wstrb   = strb;
    axi_awvalid = 1'b1;
    axi_wvalid  = 1'b1;
    axi_bready  = (bready_delay == 0);
    do @(negedge axi_clk); while (!axi_awready);
    // AW and W are taken on the same edge
    compare_flag("wready with awready", 1'b1, axi_wready);
    // partial strobes must leave memory alone
    if (&strb) begin
      shadow[addr] = data;
      exp_bresp.push_back(RESP_OKAY);
    end else begin
      exp_bresp.push_back(RESP_SLVERR);
    end
    step_to_drive();
    axi_awvalid = 1'b0;
    axi_wvalid  = 1'b0;
    do @(negedge axi_clk); while (!axi_bvalid);
    held = axi_bresp;
    repeat (bready_delay) begin
      @(negedge axi_clk);
      compare_flag("bvalid under back-pressure", 1'b1, axi_bvalid);
      check_resp("bresp under back-pressure", held, axi_bresp);
    end
    if (bready_delay > 0) begin
      step_to_drive();
      axi_bready = 1'b1;
      @(negedge axi_clk);
    end
    step_to_drive();
    axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [ADDR_WIDTH-1:0] addr, input int rready_delay = 0);
    logic [DATA_WIDTH-1:0] held;
    axi_araddr  = addr;
    axi_arvalid = 1'b1;
    axi_rready  = (rready_delay == 0);
    do @(negedge axi_clk); while (!axi_arready);
    exp_rdata.push_back(expected_read(addr));
    step_to_drive();
    axi_arvalid = 1'b0;
    do @(negedge axi_clk); while (!axi_rvalid);
    held = axi_rdata;
    repeat (rready_delay) begin
      @(negedge axi_clk);
      compare_flag("rvalid under back-pressure", 1'b1, axi_rvalid);
      check_data("rdata under back-pressure", held, axi_rdata);
    end
    if (rready_delay > 0) begin
      step_to_drive();
      axi_rready = 1'b1;
      @(negedge axi_clk);
    end
    step_to_drive();
    axi_rready = 1'b0;
  endtask

  // every B and R transfer, seen on the falling edge before it completes
  always @(negedge axi_clk) begin
    if (axi_resetn) begin
      if ((axi_bvalid || axi_rvalid) && (axi_awready || axi_wready || axi_arready)) begin
        $display("[%s] an address was accepted while a response was still pending", test_name);
        stop_run();
      end
      if (axi_bvalid && axi_bready) begin
        if (exp_bresp.size() == 0) begin
          $display("[%s] write response arrived with no write outstanding", test_name);
          stop_run();
        end
        check_resp("bresp", exp_bresp.pop_front(), axi_bresp);
        last_b_cycle = cycle_count;
      end
      if (axi_rvalid && axi_rready) begin
        if (exp_rdata.size() == 0) begin
          $display("[%s] read response arrived with no read outstanding", test_name);
          stop_run();
        end
        check_resp("rresp", RESP_OKAY, axi_rresp);
        check_data("rdata", exp_rdata.pop_front(), axi_rdata);
        last_r_cycle = cycle_count;
      end
    end
  end

  always @(posedge axi_clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      seq_state = dut.u_sram_controller.state;
      $display("run did not finish within %0d cycles, stuck in %s with sequencer in %s",
               CYCLE_LIMIT, test_name, seq_state.name());
      stop_run();
    end
  end

  initial begin
    logic [ADDR_WIDTH-1:0] addr;
    logic [STRB_WIDTH-1:0] strb;
    int                    delay;
    seed        = 32'hb32ceeb2;
    test_name   = "reset";
    axi_resetn  = 1'b0;
    axi_awaddr  = '0;
    axi_awvalid = 1'b0;
    axi_wdata   = '0;
    axi_wstrb   = '0;
    axi_wvalid  = 1'b0;
    axi_bready  = 1'b0;
    axi_araddr  = '0;
    axi_arvalid = 1'b0;
    axi_rready  = 1'b0;
    // checked just after each rising edge under reset
    repeat (RESET_CYCLES) begin
      step_to_drive();
      verify_idle_pins();
    end
    axi_resetn = 1'b1;
    repeat (2) begin
      @(negedge axi_clk);
      verify_idle_pins();
    end
    step_to_drive();

    test_name = "write then read back";
    axi_write(20'h00000, 16'h1234);
    axi_write(20'h00001, 16'habcd);
    axi_write(20'hfffff, 16'h55aa);
    axi_write(20'h80000, 16'hffff);
    axi_read(20'h00000);
    axi_read(20'h00001);
    axi_read(20'hfffff);
    axi_read(20'h80000);
    // never written, so the power-up pattern comes back
    axi_read(20'h00042);
    axi_read(20'h7ffff);

    test_name = "refused partial strobe";
    axi_write(20'h00001, 16'h0bad, 2'b01);
    check_data("memory after refused write", expected_read(20'h00001), sram.peek(20'h00001));
    axi_write(20'h00002, 16'h0bad, 2'b10);
    axi_read(20'h00001);
    axi_read(20'h00002);

    test_name = "back-pressure";
    fork
      axi_write(20'h00100, 16'hc0de, '1, 5);
      begin
        repeat (3) step_to_drive();
        axi_read(20'h00100, 4);
      end
    join

    test_name = "write priority";
    fork
      axi_write(20'h00200, 16'h2468);
      axi_read(20'h00200);
    join
    if (last_b_cycle >= last_r_cycle) begin
      $display("[%s] read response came before the write response", test_name);
      stop_run();
    end

    test_name = "random sequence";
    for (int i = 0; i < RANDOM_OPS; i++) begin
      // mostly a small window so that reads hit earlier writes
      if ($random(seed) & 1) begin
        addr = ADDR_WIDTH'($random(seed));
      end else begin
        addr = ADDR_WIDTH'($random(seed) & 31);
      end
      if (($random(seed) & 3) == 0) begin
        strb = STRB_WIDTH'($random(seed));
      end else begin
        strb = '1;
      end
      delay = $unsigned($random(seed)) % (MAX_DELAY + 1);
      if ($random(seed) & 1) begin
        axi_write(addr, DATA_WIDTH'($random(seed)), strb, delay);
      end else begin
        axi_read(addr, delay);
      end
    end

    if ((exp_bresp.size() == 0) && (exp_rdata.size() == 0)) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("%0d write and %0d read responses never arrived",
               exp_bresp.size(), exp_rdata.size());
      $display("TEST FAILED");
      $fatal(1, "responses missing at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: test/sram_model.sv
`timescale 1ns/1ns
`default_nettype none

module sram_model
  import axi_lite_pkg::*;
#(
  parameter int ADDR_WIDTH = AXI_ADDR_WIDTH_DEFAULT,
  parameter int DATA_WIDTH = AXI_DATA_WIDTH_DEFAULT
) (
  input  wire [ADDR_WIDTH-1:0] addr,
  inout  wire [DATA_WIDTH-1:0] data,
  input  wire                  ce_n,
  input  wire                  oe_n,
  input  wire                  we_n
);

  // only words that were written are stored
  logic [DATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];
  logic [DATA_WIDTH-1:0] read_word;
  logic                  reading;

  // power-up contents, a scramble of the whole address
  function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [ADDR_WIDTH-1:0] a);
    logic [31:0] wide;
    wide = 32'(a);
    return DATA_WIDTH'((wide * 32'h0000_9e37) ^ (wide >> 5) ^ 32'h0000_5a5a);
  endfunction

  // backdoor access, no bus cycle needed
  function automatic logic [DATA_WIDTH-1:0] peek(input logic [ADDR_WIDTH-1:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return fill_word(a);
  endfunction

  // the chip latches the word when we_n rises with ce_n still low
  always @(posedge we_n) begin
    if (ce_n === 1'b0) begin
      mem[addr] = data;
    end
  end

  assign reading = (ce_n === 1'b0) && (oe_n === 1'b0) && (we_n === 1'b1);

  always @(addr or reading) begin
    if (reading) begin
      read_word = peek(addr);
    end
  end

  // chip output buffers open only for a read
  assign data = reading ? read_word : {DATA_WIDTH{1'bz}};

endmodule

`default_nettype wire

// File: verilog/axi_sram_controller.sv
`timescale 1ns/1ns
`default_nettype none

module axi_sram_controller
  import axi_lite_pkg::*, sram_pkg::*;
#(
  parameter int ADDR_WIDTH  = AXI_ADDR_WIDTH_DEFAULT,
  parameter int DATA_WIDTH  = AXI_DATA_WIDTH_DEFAULT,
  parameter int WAIT_CYCLES = SRAM_WAIT_CYCLES_DEFAULT
) (
  input  wire                            axi_clk,
  input  wire                            axi_resetn,

  // write address channel
  input  wire  [ADDR_WIDTH-1:0]          axi_awaddr,
  input  wire                            axi_awvalid,
  output logic                           axi_awready,

  // write data channel
  input  wire  [DATA_WIDTH-1:0]          axi_wdata,
  input  wire  [(DATA_WIDTH+7)/8-1:0]    axi_wstrb,
  input  wire                            axi_wvalid,
  output logic                           axi_wready,

  // write response channel
  output axi_resp_t                      axi_bresp,
  output logic                           axi_bvalid,
  input  wire                            axi_bready,

  // read address channel
  input  wire  [ADDR_WIDTH-1:0]          axi_araddr,
  input  wire                            axi_arvalid,
  output logic                           axi_arready,

  // read data channel
  output logic [DATA_WIDTH-1:0]          axi_rdata,
  output axi_resp_t                      axi_rresp,
  output logic                           axi_rvalid,
  input  wire                            axi_rready,

  // sram chip
  output logic [ADDR_WIDTH-1:0]          sram_addr,
  inout  wire  [DATA_WIDTH-1:0]          sram_data,
  output logic                           sram_we_n,
  output logic                           sram_oe_n,
  output logic                           sram_ce_n
);

  // front end states
  typedef enum logic [1:0] {
    IDLE       = 2'b00,
    WRITE_WAIT = 2'b01,
    READ_WAIT  = 2'b10,
    RESP       = 2'b11
  } state_t;

  state_t state;
  state_t state_next;

  // accept decode
  logic write_pending;
  logic strb_full;
  logic write_accept;
  logic read_accept;
  logic resp_taken;

  // sequencer request and status
  logic                  sram_req;
  logic                  sram_write_enable;
  logic [ADDR_WIDTH-1:0] sram_req_addr;
  logic                  sram_ready;
  logic                  sram_write_done;
  logic                  sram_read_valid;
  logic [DATA_WIDTH-1:0] sram_read_data;

  sram_controller #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DATA_WIDTH  (DATA_WIDTH),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) u_sram_controller (
    .axi_clk      (axi_clk),
    .axi_resetn   (axi_resetn),
    .req          (sram_req),
    .write_enable (sram_write_enable),
    .addr         (sram_req_addr),
    .write_data   (axi_wdata),
    .ready        (sram_ready),
    .write_done   (sram_write_done),
    .read_valid   (sram_read_valid),
    .read_data    (sram_read_data),
    .addr_pins    (sram_addr),
    .data_pins    (sram_data),
    .we_n         (sram_we_n),
    .oe_n         (sram_oe_n),
    .ce_n         (sram_ce_n)
  );

  // a write needs both AW and W before it counts as pending
  assign write_pending = axi_awvalid && axi_wvalid;

  // the boards tie the byte lanes, so only full words are writable
  assign strb_full = &axi_wstrb;

  // write wins over a read offered in the same cycle
  assign write_accept = (state == IDLE) && sram_ready && write_pending;
  assign read_accept  = (state == IDLE) && sram_ready && axi_arvalid && !write_pending;

  assign resp_taken = (axi_bvalid && axi_bready) || (axi_rvalid && axi_rready);

  // handshakes are decoded directly from the state
  assign axi_awready = write_accept;
  assign axi_wready  = write_accept;
  assign axi_arready = read_accept;

  // refused writes never reach the chip
  assign sram_req          = (write_accept && strb_full) || read_accept;
  assign sram_write_enable = write_accept;
  assign sram_req_addr     = write_accept ? axi_awaddr : axi_araddr;

  // reads always succeed
  assign axi_rresp = RESP_OKAY;

  always_comb begin
    state_next = state;

    case (state)
      IDLE: begin
        if (write_accept) begin
          state_next = strb_full ? WRITE_WAIT : RESP;
        end else if (read_accept) begin
          state_next = READ_WAIT;
        end
      end

      WRITE_WAIT: begin
        if (sram_write_done) begin
          state_next = RESP;
        end
      end

      READ_WAIT: begin
        if (sram_read_valid) begin
          state_next = RESP;
        end
      end

      RESP: begin
        // nothing new is accepted until the master takes the response
        if (resp_taken) begin
          state_next = IDLE;
        end
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state      <= IDLE;
      axi_bvalid <= 1'b0;
      axi_rvalid <= 1'b0;
    end else begin
      state <= state_next;

      if (axi_bvalid && axi_bready) begin
        axi_bvalid <= 1'b0;
      end else if (write_accept && !strb_full) begin
        axi_bvalid <= 1'b1;
      end else if ((state == WRITE_WAIT) && sram_write_done) begin
        axi_bvalid <= 1'b1;
      end

      if (axi_rvalid && axi_rready) begin
        axi_rvalid <= 1'b0;
      end else if ((state == READ_WAIT) && sram_read_valid) begin
        axi_rvalid <= 1'b1;
      end
    end
  end

  // response payload, held steady while valid is up
  always_ff @(posedge axi_clk) begin
    if (write_accept && !strb_full) begin
      axi_bresp <= RESP_SLVERR;
    end else if ((state == WRITE_WAIT) && sram_write_done) begin
      axi_bresp <= RESP_OKAY;
    end

    if ((state == READ_WAIT) && sram_read_valid) begin
      axi_rdata <= sram_read_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/sram_controller.sv
`timescale 1ns/1ns
`default_nettype none

module sram_controller
  import axi_lite_pkg::*, sram_pkg::*;
#(
  parameter int ADDR_WIDTH  = AXI_ADDR_WIDTH_DEFAULT,
  parameter int DATA_WIDTH  = AXI_DATA_WIDTH_DEFAULT,
  parameter int WAIT_CYCLES = SRAM_WAIT_CYCLES_DEFAULT
) (
  input  wire                   axi_clk,
  input  wire                   axi_resetn,

  // request side
  input  wire                   req,
  input  wire                   write_enable,
  input  wire  [ADDR_WIDTH-1:0] addr,
  input  wire  [DATA_WIDTH-1:0] write_data,
  output logic                  ready,
  output logic                  write_done,
  output logic                  read_valid,
  output logic [DATA_WIDTH-1:0] read_data,

  // chip pins
  output logic [ADDR_WIDTH-1:0] addr_pins,
  inout  wire  [DATA_WIDTH-1:0] data_pins,
  output logic                  we_n,
  output logic                  oe_n,
  output logic                  ce_n
);

  // counter must be at least one bit wide even for zero wait cycles
  localparam int CNT_WIDTH = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  sram_state_t          state;
  sram_state_t          state_next;
  logic [CNT_WIDTH-1:0] wait_cnt;
  logic [CNT_WIDTH-1:0] wait_cnt_next;

  // latched request
  logic                  start;
  logic                  write_q;
  logic                  write_next;
  logic [DATA_WIDTH-1:0] wdata_q;

  // data bus output enable
  logic                  drive_q;
  logic                  capture;

  assign start = (state == IDLE) && req;

  // direction of the access in progress, or of the one being started
  assign write_next = start ? write_enable : write_q;

  // sample the chip on the last ACCESS cycle while oe_n is still low
  assign capture = (state == ACCESS) && (state_next == HOLD) && !write_q;

  always_comb begin
    state_next    = state;
    wait_cnt_next = wait_cnt;

    case (state)
      IDLE: begin
        if (req) begin
          state_next    = ACCESS;
          wait_cnt_next = CNT_WIDTH'(WAIT_CYCLES);
        end
      end

      ACCESS: begin
        // W+1 cycles in total, counting down to zero
        if (wait_cnt == '0) begin
          state_next = HOLD;
        end else begin
          wait_cnt_next = wait_cnt - 1'b1;
        end
      end

      HOLD: begin
        state_next = TURN;
      end

      TURN: begin
        state_next = IDLE;
      end

      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // state, counter and strobes
  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state    <= IDLE;
      wait_cnt <= '0;
      write_q  <= 1'b0;
      ce_n     <= 1'b1;
      we_n     <= 1'b1;
      oe_n     <= 1'b1;
      drive_q  <= 1'b0;
    end else begin
      state    <= state_next;
      wait_cnt <= wait_cnt_next;
      write_q  <= write_next;

      // strobes are registered so the chip pins never glitch on a state change
      ce_n    <= !((state_next == ACCESS) || (state_next == HOLD));
      we_n    <= !((state_next == ACCESS) && write_next);
      oe_n    <= !((state_next == ACCESS) && !write_next);

      // write data stays on the bus through HOLD for the chip hold time
      drive_q <= ((state_next == ACCESS) || (state_next == HOLD)) && write_next;
    end
  end

  // address, write data and read data
  always_ff @(posedge axi_clk) begin
    if (start) begin
      addr_pins <= addr;
      wdata_q   <= write_data;
    end

    if (capture) begin
      read_data <= data_pins;
    end
  end

  // released everywhere except write ACCESS and HOLD
  assign data_pins = drive_q ? wdata_q : {DATA_WIDTH{1'bz}};

  assign ready      = (state == IDLE);
  assign write_done = (state == HOLD) && write_q;
  assign read_valid = (state == HOLD) && !write_q;

endmodule

`default_nettype wire

// File: verilog/sram_pkg.sv
`default_nettype none

package sram_pkg;

  // pin sequencer states
  //   IDLE   waiting for a request, bus released
  //   ACCESS chip enabled with we_n or oe_n low
  //   HOLD   strobes released, address and data still held
  //   TURN   one dead cycle before the next access
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    ACCESS = 2'b01,
    HOLD   = 2'b10,
    TURN   = 2'b11
  } sram_state_t;

  // extra ACCESS cycles to cover the chip access time
  localparam int SRAM_WAIT_CYCLES_DEFAULT = 2;

endpackage

`default_nettype wire

// File: verilog/axi_lite_pkg.sv
`default_nettype none

package axi_lite_pkg;

  // response codes returned by the slave
  // EXOKAY and DECERR never occur here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_t;

  // default bus widths
  // one address selects one sram word
  localparam int AXI_ADDR_WIDTH_DEFAULT = 20;
  localparam int AXI_DATA_WIDTH_DEFAULT = 16;

endpackage

`default_nettype wire
